/* include/mac_ctrl_defs.svh */
// MAC control receive defines

`ifndef MAC_CTRL_DEFS_SVH
`define MAC_CTRL_DEFS_SVH

// receive stream geometry
`define DATA_W 64
`define KEEP_W (`DATA_W/8)

// fixed MAC control frame fields (annex 31B)
// reserved multicast destination 01-80-C2-00-00-01
`define MCF_DST 48'h01_80_C2_00_00_01

// MAC control EtherType
`define MCF_ETH_TYPE 16'h8808

// PAUSE opcode
`define LFC_OPCODE 16'h0001

// one quantum is 512 bit times
`define QUANTA_CYCLES (512/`DATA_W)

// statistics counter width
`define STAT_W 16

`endif

/* hdl/mac_ctrl_pkg.sv */
// MAC control receive types

`include "mac_ctrl_defs.svh"

package mac_ctrl_pkg;

    // stream beat and lane enables
    typedef logic [`DATA_W-1:0] data_t;
    typedef logic [`KEEP_W-1:0] keep_t;

    // control frame header fields
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] eth_type_t;
    typedef logic [15:0] opcode_t;

    // pause time in quanta
    typedef logic [15:0] quanta_t;

    // statistics count
    typedef logic [`STAT_W-1:0] stat_t;

    // beat position inside a received frame
    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_HDR1,
        DEC_PARAM,
        DEC_DRAIN
    } decode_state_t;

endpackage

/* hdl/mcf_decode.sv */
// MAC control frame decoder

`timescale 1ns/1ps

`include "mac_ctrl_defs.svh"

module mcf_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  mac_ctrl_pkg::data_t   rx_tdata,
    input  mac_ctrl_pkg::keep_t   rx_tkeep,
    input  logic                  rx_tvalid,
    input  logic                  rx_tlast,
    input  logic                  rx_tuser,
    output logic                  mcf_valid,
    output logic                  mcf_is_lfc,
    output mac_ctrl_pkg::quanta_t mcf_quanta
);

    import mac_ctrl_pkg::*;

    decode_state_t state;

    // header fields as they sit in the current beat
    mac_addr_t beat_dst;
    eth_type_t beat_type;
    opcode_t   beat_opcode;
    quanta_t   beat_quanta;

    // per-field match flags held until frame end
    logic dst_ok;
    logic type_ok;
    logic op_ok;

    logic frame_end;

    // byte 0 leads on the wire and multi-byte fields are big endian
    assign beat_dst = {rx_tdata[7:0], rx_tdata[15:8], rx_tdata[23:16],
                       rx_tdata[31:24], rx_tdata[39:32], rx_tdata[47:40]};
    assign beat_type = {rx_tdata[39:32], rx_tdata[47:40]};
    assign beat_opcode = {rx_tdata[55:48], rx_tdata[63:56]};
    assign beat_quanta = {rx_tdata[7:0], rx_tdata[15:8]};

    // only frames that reached the parameter beat can qualify
    assign frame_end = rx_tvalid && rx_tlast &&
                       (state == DEC_PARAM || state == DEC_DRAIN);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DEC_IDLE;
            mcf_valid <= 1'b0;
        end else begin
            mcf_valid <= 1'b0;

            if (rx_tvalid) begin
                case (state)
                    DEC_IDLE: begin
                        // destination needs all six lanes present
                        dst_ok <= (rx_tkeep[5:0] == 6'h3f) && (beat_dst == `MCF_DST);
                        state <= rx_tlast ? DEC_IDLE : DEC_HDR1;
                    end
                    DEC_HDR1: begin
                        type_ok <= (rx_tkeep[5:4] == 2'b11) &&
                                   (beat_type == `MCF_ETH_TYPE);
                        op_ok <= (rx_tkeep[7:6] == 2'b11) &&
                                 (beat_opcode == `LFC_OPCODE);
                        state <= rx_tlast ? DEC_IDLE : DEC_PARAM;
                    end
                    DEC_PARAM: begin
                        mcf_quanta <= beat_quanta;
                        state <= rx_tlast ? DEC_IDLE : DEC_DRAIN;
                    end
                    default: begin
                        // trailing payload is ignored
                        state <= rx_tlast ? DEC_IDLE : DEC_DRAIN;
                    end
                endcase
            end

            // bad frame flag is only valid on the last beat
            if (frame_end) begin
                mcf_valid <= dst_ok && type_ok && !rx_tuser;
                mcf_is_lfc <= op_ok;
            end
        end
    end

endmodule

/* hdl/pause_timer.sv */
// PAUSE quanta timer

`timescale 1ns/1ps

`include "mac_ctrl_defs.svh"

module pause_timer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  mcf_valid,
    input  logic                  mcf_is_lfc,
    input  mac_ctrl_pkg::quanta_t mcf_quanta,
    input  logic                  rx_lfc_en,
    input  logic                  rx_lfc_ack,
    output logic                  rx_lfc_req,
    output logic                  lfc_paused
);

    import mac_ctrl_pkg::*;

    localparam int PRESC_W = $clog2(`QUANTA_CYCLES);
    localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(`QUANTA_CYCLES - 1);

    quanta_t            quanta_cnt;
    logic [PRESC_W-1:0] presc;
    logic               load;

    // XON restarts the timer like any newer PAUSE
    assign load = mcf_valid && mcf_is_lfc && rx_lfc_en;

    always_ff @(posedge clk) begin
        if (reset) begin
            quanta_cnt <= '0;
            presc <= '0;
            rx_lfc_req <= 1'b0;
            lfc_paused <= 1'b0;
        end else begin
            // transmitter confirmed the stop in this cycle
            lfc_paused <= rx_lfc_req && rx_lfc_ack;

            if (load) begin
                quanta_cnt <= mcf_quanta;
                presc <= '0;
                rx_lfc_req <= (mcf_quanta != '0);
            end else if (quanta_cnt != '0) begin
                if (presc == PRESC_LAST) begin
                    presc <= '0;
                    quanta_cnt <= quanta_cnt - quanta_t'(1);
                    // release together with the last quantum
                    rx_lfc_req <= (quanta_cnt != quanta_t'(1));
                end else begin
                    presc <= presc + 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/pause_stats.sv */
// MAC control receive statistics

`timescale 1ns/1ps

module pause_stats (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  mcf_valid,
    input  logic                  mcf_is_lfc,
    input  mac_ctrl_pkg::quanta_t mcf_quanta,
    input  logic                  lfc_paused,
    output mac_ctrl_pkg::stat_t   stat_rx_mcf,
    output mac_ctrl_pkg::stat_t   stat_rx_lfc_pkt,
    output mac_ctrl_pkg::stat_t   stat_rx_lfc_xon,
    output mac_ctrl_pkg::stat_t   stat_rx_lfc_xoff,
    output mac_ctrl_pkg::stat_t   stat_rx_lfc_paused
);

    import mac_ctrl_pkg::*;

    logic lfc_frame;
    logic xon_frame;

    // counted even when pause reception is disabled
    assign lfc_frame = mcf_valid && mcf_is_lfc;
    assign xon_frame = (mcf_quanta == '0);

    // all counters wrap
    always_ff @(posedge clk) begin
        if (reset) begin
            stat_rx_mcf <= '0;
            stat_rx_lfc_pkt <= '0;
            stat_rx_lfc_xon <= '0;
            stat_rx_lfc_xoff <= '0;
            stat_rx_lfc_paused <= '0;
        end else begin
            if (mcf_valid) begin
                stat_rx_mcf <= stat_rx_mcf + stat_t'(1);
            end
            if (lfc_frame) begin
                stat_rx_lfc_pkt <= stat_rx_lfc_pkt + stat_t'(1);
            end
            if (lfc_frame && xon_frame) begin
                stat_rx_lfc_xon <= stat_rx_lfc_xon + stat_t'(1);
            end
            if (lfc_frame && !xon_frame) begin
                stat_rx_lfc_xoff <= stat_rx_lfc_xoff + stat_t'(1);
            end
            if (lfc_paused) begin
                stat_rx_lfc_paused <= stat_rx_lfc_paused + stat_t'(1);
            end
        end
    end

endmodule

/* hdl/mac_pause_rx.sv */
// PAUSE receive top level

`timescale 1ns/1ps

module mac_pause_rx (
    input  logic                clk,
    input  logic                reset,
    input  mac_ctrl_pkg::data_t rx_tdata,
    input  mac_ctrl_pkg::keep_t rx_tkeep,
    input  logic                rx_tvalid,
    input  logic                rx_tlast,
    input  logic                rx_tuser,
    input  logic                rx_lfc_en,
    input  logic                rx_lfc_ack,
    output logic                rx_lfc_req,
    output mac_ctrl_pkg::stat_t stat_rx_mcf,
    output mac_ctrl_pkg::stat_t stat_rx_lfc_pkt,
    output mac_ctrl_pkg::stat_t stat_rx_lfc_xon,
    output mac_ctrl_pkg::stat_t stat_rx_lfc_xoff,
    output mac_ctrl_pkg::stat_t stat_rx_lfc_paused
);

    import mac_ctrl_pkg::*;

    // decoded control frame
    logic    mcf_valid;
    logic    mcf_is_lfc;
    quanta_t mcf_quanta;

    logic    lfc_paused;

    mcf_decode mcf_decode_i (
        .clk        (clk),
        .reset      (reset),
        .rx_tdata   (rx_tdata),
        .rx_tkeep   (rx_tkeep),
        .rx_tvalid  (rx_tvalid),
        .rx_tlast   (rx_tlast),
        .rx_tuser   (rx_tuser),
        .mcf_valid  (mcf_valid),
        .mcf_is_lfc (mcf_is_lfc),
        .mcf_quanta (mcf_quanta)
    );

    pause_timer pause_timer_i (
        .clk        (clk),
        .reset      (reset),
        .mcf_valid  (mcf_valid),
        .mcf_is_lfc (mcf_is_lfc),
        .mcf_quanta (mcf_quanta),
        .rx_lfc_en  (rx_lfc_en),
        .rx_lfc_ack (rx_lfc_ack),
        .rx_lfc_req (rx_lfc_req),
        .lfc_paused (lfc_paused)
    );

    pause_stats pause_stats_i (
        .clk                (clk),
        .reset              (reset),
        .mcf_valid          (mcf_valid),
        .mcf_is_lfc         (mcf_is_lfc),
        .mcf_quanta         (mcf_quanta),
        .lfc_paused         (lfc_paused),
        .stat_rx_mcf        (stat_rx_mcf),
        .stat_rx_lfc_pkt    (stat_rx_lfc_pkt),
        .stat_rx_lfc_xon    (stat_rx_lfc_xon),
        .stat_rx_lfc_xoff   (stat_rx_lfc_xoff),
        .stat_rx_lfc_paused (stat_rx_lfc_paused)
    );

endmodule

/* tb/mac_pause_rx_checker.sv */
// PAUSE receive response checker

`timescale 1ns/1ps

`include "mac_ctrl_defs.svh"

module mac_pause_rx_checker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rx_lfc_req,
    input  mac_ctrl_pkg::stat_t   stat_rx_mcf,
    input  mac_ctrl_pkg::stat_t   stat_rx_lfc_pkt,
    input  mac_ctrl_pkg::stat_t   stat_rx_lfc_xon,
    input  mac_ctrl_pkg::stat_t   stat_rx_lfc_xoff,
    input  mac_ctrl_pkg::stat_t   stat_rx_lfc_paused,
    input  logic                  frame_done,
    input  logic                  exp_load,
    input  mac_ctrl_pkg::quanta_t exp_quanta,
    input  logic [3:0]            exp_deltas,
    input  mac_ctrl_pkg::stat_t   exp_d_paused,
    input  logic                  end_check,
    output int                    err_cnt
);

    import mac_ctrl_pkg::*;

    // expected counter values
    stat_t exp_mcf;
    stat_t exp_pkt;
    stat_t exp_xon;
    stat_t exp_xoff;
    stat_t exp_paused;

    // last beat was sampled on the previous edge
    logic        pend;
    int unsigned req_left;
    int          errors = 0;

    assign err_cnt = errors;

    task automatic compare_stat(input string name, input stat_t actual, input stat_t expected);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            pend <= 1'b0;
            exp_mcf <= '0;
            exp_pkt <= '0;
            exp_xon <= '0;
            exp_xoff <= '0;
            exp_paused <= '0;
            req_left <= 0;
        end else begin
            pend <= frame_done;
            // counters move 2 cycles after the last beat
            if (pend) begin
                exp_mcf <= exp_mcf + stat_t'(exp_deltas[3]);
                exp_pkt <= exp_pkt + stat_t'(exp_deltas[2]);
                exp_xon <= exp_xon + stat_t'(exp_deltas[1]);
                exp_xoff <= exp_xoff + stat_t'(exp_deltas[0]);
                exp_paused <= exp_paused + exp_d_paused;
            end
            // request window of quanta x cycles per quantum
            if (pend && exp_load) begin
                req_left <= 32'(exp_quanta) * `QUANTA_CYCLES;
            end else if (req_left != 0) begin
                req_left <= req_left - 1;
            end
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (rx_lfc_req !== (req_left != 0)) begin
                $display("ERR %0t: rx_lfc_req is %b, expected %b", $time, rx_lfc_req,
                         req_left != 0);
                errors++;
            end
            compare_stat("stat_rx_mcf", stat_rx_mcf, exp_mcf);
            compare_stat("stat_rx_lfc_pkt", stat_rx_lfc_pkt, exp_pkt);
            compare_stat("stat_rx_lfc_xon", stat_rx_lfc_xon, exp_xon);
            compare_stat("stat_rx_lfc_xoff", stat_rx_lfc_xoff, exp_xoff);
            // paused count settles only after the request drops
            if (end_check) begin
                compare_stat("stat_rx_lfc_paused", stat_rx_lfc_paused, exp_paused);
            end
        end
    end

endmodule

/* tb/mac_pause_rx_tb.sv */
// PAUSE receive testbench

`timescale 1ns/1ps

`include "mac_ctrl_defs.svh"

module mac_pause_rx_tb;

    import mac_ctrl_pkg::*;

    localparam int NUM_ROWS = 11;
    localparam int REQ_TIMEOUT = 2000;
    localparam mac_addr_t OTHER_DST = 48'h01_80_C2_00_00_02;

    // flags are {bad, en, ack, hold}
    // deltas are {mcf, lfc_pkt, xon, xoff}
    typedef struct packed {
        mac_addr_t  dst;
        eth_type_t  etype;
        opcode_t    opcode;
        quanta_t    quanta;
        logic [3:0] beats;
        logic [3:0] flags;
        logic [3:0] deltas;
        stat_t      d_paused;
    } row_t;

    logic    clk = 1'b0;
    logic    reset;
    data_t   rx_tdata;
    keep_t   rx_tkeep;
    logic    rx_tvalid;
    logic    rx_tlast;
    logic    rx_tuser;
    logic    rx_lfc_en;
    logic    rx_lfc_ack;
    logic    rx_lfc_req;
    stat_t   stat_rx_mcf;
    stat_t   stat_rx_lfc_pkt;
    stat_t   stat_rx_lfc_xon;
    stat_t   stat_rx_lfc_xoff;
    stat_t   stat_rx_lfc_paused;

    // expectations handed to the checker
    logic       frame_done;
    logic       exp_load;
    quanta_t    exp_quanta;
    logic [3:0] exp_deltas;
    stat_t      exp_d_paused;
    logic       end_check;
    int         err_cnt;

    row_t        rows [NUM_ROWS];
    logic [31:0] lcg_state = 32'd40245;
    logic        timed_out = 1'b0;
    int          fails = 0;
    int          tests_run = 0;

    always #20 clk = ~clk;

    mac_pause_rx mac_pause_rx_i (.*);

    mac_pause_rx_checker mac_pause_rx_checker_i (.*);

    initial begin
        rows[0] = '{`MCF_DST, `MCF_ETH_TYPE, `LFC_OPCODE, 16'd3, 4'd3, 4'b0100, 4'b1101, 16'd0};
        rows[1] = '{`MCF_DST, `MCF_ETH_TYPE, `LFC_OPCODE, 16'd2, 4'd3, 4'b0110, 4'b1101, 16'd16};
        // long pause left running, then XON cuts it short
        rows[2] = '{`MCF_DST, `MCF_ETH_TYPE, `LFC_OPCODE, 16'd100, 4'd4, 4'b0101, 4'b1101, 16'd0};
        rows[3] = '{`MCF_DST, `MCF_ETH_TYPE, `LFC_OPCODE, 16'd0, 4'd3, 4'b0100, 4'b1110, 16'd0};
        rows[4] = '{OTHER_DST, `MCF_ETH_TYPE, `LFC_OPCODE, 16'd5, 4'd3, 4'b0100, 4'b0000, 16'd0};
        rows[5] = '{`MCF_DST, 16'h0800, `LFC_OPCODE, 16'd5, 4'd3, 4'b0100, 4'b0000, 16'd0};
        rows[6] = '{`MCF_DST, `MCF_ETH_TYPE, 16'h0101, 16'd5, 4'd3, 4'b0100, 4'b1000, 16'd0};
        // bad frame, then a two beat frame
        rows[7] = '{`MCF_DST, `MCF_ETH_TYPE, `LFC_OPCODE, 16'd4, 4'd3, 4'b1100, 4'b0000, 16'd0};
        rows[8] = '{`MCF_DST, `MCF_ETH_TYPE, `LFC_OPCODE, 16'd4, 4'd2, 4'b0100, 4'b0000, 16'd0};
        rows[9] = '{`MCF_DST, `MCF_ETH_TYPE, `LFC_OPCODE, 16'd4, 4'd3, 4'b0000, 4'b1101, 16'd0};
        rows[10] = '{`MCF_DST, `MCF_ETH_TYPE, `LFC_OPCODE, 16'd1, 4'd5, 4'b0110, 4'b1101, 16'd8};
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // timer loads only on a good PAUSE with reception enabled
    function automatic logic pause_loads(input row_t r);
        logic qualifies;
        qualifies = (r.dst == `MCF_DST) && (r.etype == `MCF_ETH_TYPE) &&
                    (r.beats >= 4'd3) && !r.flags[3];
        return qualifies && (r.opcode == `LFC_OPCODE) && r.flags[2];
    endfunction

    // byte 0 leads on the wire and fields go high byte first
    function automatic data_t make_beat(input row_t r, input int b);
        data_t beat;
        beat = {next_rand(), next_rand()};
        case (b)
            0: begin
                for (int n = 0; n < 6; n++) begin
                    beat[8*n +: 8] = r.dst[8*(5-n) +: 8];
                end
            end
            1: beat[63:32] = {r.opcode[7:0], r.opcode[15:8], r.etype[7:0], r.etype[15:8]};
            2: beat[15:0] = {r.quanta[7:0], r.quanta[15:8]};
            default: ;
        endcase
        return beat;
    endfunction

    task automatic send_frame(input row_t r);
        logic last;
        for (int b = 0; b < int'(r.beats); b++) begin
            last = (b == int'(r.beats) - 1);
            @(posedge clk);
            rx_tdata <= make_beat(r, b);
            rx_tkeep <= '1;
            rx_tvalid <= 1'b1;
            rx_tlast <= last;
            rx_tuser <= last && r.flags[3];
            frame_done <= last;
        end
        @(posedge clk);
        rx_tvalid <= 1'b0;
        rx_tlast <= 1'b0;
        rx_tuser <= 1'b0;
        frame_done <= 1'b0;
    endtask

    task automatic wait_req_low(input int test);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (rx_lfc_req && cycles < REQ_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (rx_lfc_req) begin
            $display("timeout: rx_lfc_req still high after %0d cycles in test %0d", cycles, test);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int errs_before;
        reset <= 1'b1;
        rx_tdata <= '0;
        rx_tkeep <= '0;
        rx_tvalid <= 1'b0;
        rx_tlast <= 1'b0;
        rx_tuser <= 1'b0;
        rx_lfc_en <= 1'b0;
        rx_lfc_ack <= 1'b0;
        frame_done <= 1'b0;
        exp_load <= 1'b0;
        exp_quanta <= '0;
        exp_deltas <= '0;
        exp_d_paused <= '0;
        end_check <= 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
            errs_before = err_cnt;
            @(posedge clk);
            rx_lfc_en <= rows[i].flags[2];
            rx_lfc_ack <= rows[i].flags[1];
            exp_load <= pause_loads(rows[i]);
            exp_quanta <= rows[i].quanta;
            exp_deltas <= rows[i].deltas;
            exp_d_paused <= rows[i].d_paused;
            send_frame(rows[i]);
            repeat (2) @(posedge clk);
            if (!rows[i].flags[0]) begin
                wait_req_low(i);
            end
            // paused count needs two more edges after release
            repeat (3) @(posedge clk);
            end_check <= 1'b1;
            @(posedge clk);
            end_check <= 1'b0;
            rx_lfc_ack <= 1'b0;
            tests_run++;
            if (err_cnt != errs_before || timed_out) begin
                fails++;
                $display("test %0d: mismatch", i);
            end else begin
                $display("test %0d: ok", i);
            end
        end

        $display("%0d of %0d tests run, %0d failing, %0d check errors",
                 tests_run, NUM_ROWS, fails, err_cnt);
        if (fails == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+include
hdl/mac_ctrl_pkg.sv
hdl/mcf_decode.sv
hdl/pause_timer.sv
hdl/pause_stats.sv
hdl/mac_pause_rx.sv
tb/mac_pause_rx_checker.sv
tb/mac_pause_rx_tb.sv

/* Bender.yml */
package:
  name: mac_pause_rx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/mac_ctrl_pkg.sv
      - hdl/mcf_decode.sv
      - hdl/pause_timer.sv
      - hdl/pause_stats.sv
      - hdl/mac_pause_rx.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/mac_pause_rx_checker.sv
      - tb/mac_pause_rx_tb.sv
